// ==== fpCvt_settings.svh ====
//**************************************************************************
// float-to-integer converter settings
// exponent bias, operand buffer depth and operand widths
//**************************************************************************

`ifndef FPCVT_SETTINGS_SVH
`define FPCVT_SETTINGS_SVH

// bias of the common 16-bit exponent, shared by every operand format
`define FPCVT_EXP_BIAS 16'h7fff

// entries in the unpacked operand buffer
// 2, 4 and 8 are all valid choices
`define FPCVT_FIFO_DEPTH 4

// register-file operand width
`define FPCVT_OP_WIDTH 82

// integer result width
`define FPCVT_INT_WIDTH 64

`endif

// ==== fpCvtPkg.sv ====
//**************************************************************************
// float-to-integer converter types
// operand, exponent, mantissa and result vectors plus the format encoding
//**************************************************************************

`include "fpCvt_settings.svh"

package fpCvtPkg;

  // operand as it sits in the floating-point register file
  typedef logic [`FPCVT_OP_WIDTH-1:0] fpReg_t;

  // biased exponent, bias 0x7fff for every format
  typedef logic [15:0] cvtExp_t;

  // left-aligned mantissa with the leading one made explicit
  typedef logic [63:0] cvtMant_t;

  // two's-complement conversion result
  typedef logic [`FPCVT_INT_WIDTH-1:0] cvtInt_t;

  // operand format, one bit per format so it doubles as the strobe set
  typedef enum logic [3:0] {
    sng      = 4'b0001,
    dbl      = 4'b0010,
    ext      = 4'b0100,
    verbatim = 4'b1000
  } fpFmt_e;

endpackage

// ==== fpOperandUnpack.sv ====
//**************************************************************************
// operand unpacker
// splits a register operand into sign, rebiased exponent and mantissa
//**************************************************************************

`timescale 1ns/1ps

`include "fpCvt_settings.svh"

module fpOperandUnpack (
  input  logic               clk,
  input  logic               arstN,
  input  logic               en,
  input  fpCvtPkg::fpReg_t   A,
  input  fpCvtPkg::fpFmt_e   fmt,
  input  logic               is32b,
  output logic               unpValid,
  output logic               unpSign,
  output fpCvtPkg::cvtExp_t  unpExp,
  output fpCvtPkg::cvtMant_t unpMant,
  output logic               unpIs32b
);
  import fpCvtPkg::*;

  // ext and verbatim share this mantissa layout, bit 32 is skipped
  cvtMant_t mantExt;

  logic     fieldSign;
  cvtExp_t  fieldExp;
  cvtMant_t fieldMant;

  assign mantExt = {A[64:33], A[31:0]};

  //************************************************************************
  // field extraction
  //************************************************************************
  always_comb begin
    fieldSign = 1'b0;
    fieldExp  = '0;
    fieldMant = '0;
    case (fmt)
      ext: begin
        fieldSign = A[80];
        fieldExp  = {A[81], A[79:65]};
        fieldMant = mantExt;
      end
      dbl: begin
        fieldSign = A[64];
        // top exponent bit is copied into the bias gap
        fieldExp  = {A[63], {5{~A[63]}}, A[62:53]};
        fieldMant = {1'b1, A[52:33], A[31:0], 11'b0};
      end
      sng: begin
        fieldSign = A[31];
        fieldExp  = {A[30], {8{~A[30]}}, A[29:23]};
        fieldMant = {1'b1, A[22:0], 40'b0};
      end
      verbatim: begin
        // exponent 63 makes the converter return the mantissa as is
        fieldSign = 1'b0;
        fieldExp  = `FPCVT_EXP_BIAS + 16'd63;
        fieldMant = mantExt;
      end
      default: begin
        fieldSign = 1'b0;
        fieldExp  = '0;
        fieldMant = '0;
      end
    endcase
  end

  //************************************************************************
  // output register
  //************************************************************************
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      unpValid <= 1'b0;
    end else begin
      unpValid <= en;
    end
  end

  always_ff @(posedge clk) begin
    if (en) begin
      unpSign  <= fieldSign;
      unpExp   <= fieldExp;
      unpMant  <= fieldMant;
      unpIs32b <= is32b;
    end
  end

endmodule

// ==== cvtOperandFifo.sv ====
//**************************************************************************
// unpacked operand FIFO
// holds operands between the unpacker and the converter
//**************************************************************************

`timescale 1ns/1ps

module cvtOperandFifo #(
  parameter int unsigned depth = 4
) (
  input  logic               clk,
  input  logic               arstN,
  input  logic               push,
  input  logic               inSign,
  input  fpCvtPkg::cvtExp_t  inExp,
  input  fpCvtPkg::cvtMant_t inMant,
  input  logic               inIs32b,
  input  logic               pop,
  output logic               outSign,
  output fpCvtPkg::cvtExp_t  outExp,
  output fpCvtPkg::cvtMant_t outMant,
  output logic               outIs32b,
  output logic               notEmpty,
  output logic               full
);
  import fpCvtPkg::*;

  localparam int unsigned ptrWidth = (depth > 1) ? $clog2(depth) : 1;
  localparam int unsigned cntWidth = $clog2(depth + 1);

  logic     memSign [depth];
  cvtExp_t  memExp  [depth];
  cvtMant_t memMant [depth];
  logic     memIs32b[depth];

  logic [ptrWidth-1:0] wrPtr;
  logic [ptrWidth-1:0] rdPtr;
  logic [cntWidth-1:0] count;
  logic                doPush;
  logic                doPop;

  // pointer advance with wrap at the last entry
  function automatic logic [ptrWidth-1:0] nextPtr(input logic [ptrWidth-1:0] ptr);
    if (ptr == ptrWidth'(depth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // a pop in the same cycle frees the head slot for a push into a full FIFO
  assign doPush = push & (~full | doPop);
  assign doPop  = pop & notEmpty;

  assign notEmpty = (count != '0);
  assign full     = (count == cntWidth'(depth));

  // head entry is visible without a register stage
  assign outSign  = memSign[rdPtr];
  assign outExp   = memExp[rdPtr];
  assign outMant  = memMant[rdPtr];
  assign outIs32b = memIs32b[rdPtr];

  always_ff @(posedge clk) begin
    if (doPush) begin
      memSign[wrPtr]  <= inSign;
      memExp[wrPtr]   <= inExp;
      memMant[wrPtr]  <= inMant;
      memIs32b[wrPtr] <= inIs32b;
    end
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (doPush) begin
        wrPtr <= nextPtr(wrPtr);
      end
      if (doPop) begin
        rdPtr <= nextPtr(rdPtr);
      end
      if (doPush && !doPop) begin
        count <= count + 1'b1;
      end else if (doPop && !doPush) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

// ==== fpToIntConvert.sv ====
//**************************************************************************
// float-to-integer converter
// two-stage shifter rounding toward minus infinity, with range saturation
//**************************************************************************

`timescale 1ns/1ps

`include "fpCvt_settings.svh"

module fpToIntConvert (
  input  logic               clk,
  input  logic               arstN,
  input  logic               clkEn,
  input  logic               notEmpty,
  input  logic               sign,
  input  fpCvtPkg::cvtExp_t  exp,
  input  fpCvtPkg::cvtMant_t mant,
  input  logic               is32b,
  output logic               pop,
  output fpCvtPkg::cvtInt_t  res,
  output logic               resValid
);
  import fpCvtPkg::*;

  // unbiased exponent above 63 or below -63
  localparam cvtExp_t expUpLimit = `FPCVT_EXP_BIAS + 16'd64;
  localparam cvtExp_t expDnLimit = `FPCVT_EXP_BIAS - 16'd63;

  // stage 1 combinational
  logic [64:0]  signedMant;
  logic [3:0]   coarseSel;
  logic [191:0] wideShift;
  logic [71:0]  coarseVal;
  logic         overUp;
  logic         underDn;

  // stage 1 registers
  logic [71:0]  s1Val;
  logic [2:0]   s1Fine;
  logic         s1Sign;
  logic         s1OverUp;
  logic         s1UnderDn;
  logic         s1Is32b;
  logic         s1Valid;

  // stage 2 combinational
  logic [71:0]  fineShift;
  cvtInt_t      fineVal;
  cvtInt_t      resNext;

  assign pop = clkEn & notEmpty;

  //************************************************************************
  // stage 1: range flags, negation and byte shift
  //************************************************************************
  assign overUp  = (exp >= expUpLimit);
  assign underDn = (exp < expDnLimit);

  // negating before an arithmetic shift gives floor for negative values
  assign signedMant = sign ? (65'd0 - {1'b0, mant}) : {1'b0, mant};

  // left shift amount is E+63, in range its low 7 bits are {~exp[7], exp[5:0]}
  assign coarseSel = {~exp[7], exp[5:3]};
  assign wideShift = {{127{signedMant[64]}}, signedMant} << {coarseSel, 3'b000};

  // window keeps 8 spare low bits for the fine shift
  assign coarseVal = wideShift[189:118];

  //************************************************************************
  // stage 2: bit shift and saturation
  //************************************************************************
  assign fineShift = s1Val >> (4'd8 - {1'b0, s1Fine});
  assign fineVal   = fineShift[`FPCVT_INT_WIDTH-1:0];

  always_comb begin
    if (s1OverUp) begin
      resNext = '0;
    end else if (s1UnderDn) begin
      resNext = {`FPCVT_INT_WIDTH{s1Sign}};
    end else begin
      resNext = fineVal;
    end
    // 32-bit requests drop the upper word whatever the range
    if (s1Is32b) begin
      resNext[`FPCVT_INT_WIDTH-1:`FPCVT_INT_WIDTH/2] = '0;
    end
  end

  //************************************************************************
  // pipeline registers
  //************************************************************************
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      s1Valid  <= 1'b0;
      resValid <= 1'b0;
    end else begin
      resValid <= clkEn & s1Valid;
      if (clkEn) begin
        s1Valid <= pop;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      s1Val     <= coarseVal;
      s1Fine    <= exp[2:0];
      s1Sign    <= sign;
      s1OverUp  <= overUp;
      s1UnderDn <= underDn;
      s1Is32b   <= is32b;
    end
    if (clkEn && s1Valid) begin
      res <= resNext;
    end
  end

endmodule

// ==== fpCvtUnit.sv ====
//**************************************************************************
// float-to-integer conversion unit
// unpacker feeding a FIFO that feeds the two-stage converter
//**************************************************************************

`timescale 1ns/1ps

`include "fpCvt_settings.svh"

module fpCvtUnit (
  input  logic              clk,
  input  logic              arstN,
  input  logic              en,
  input  logic              clkEn,
  input  fpCvtPkg::fpReg_t  A,
  input  fpCvtPkg::fpFmt_e  fmt,
  input  logic              is32b,
  output fpCvtPkg::cvtInt_t res,
  output logic              resValid,
  output logic              busy
);
  import fpCvtPkg::*;

  // unpacker to FIFO
  logic     unpValid;
  logic     unpSign;
  cvtExp_t  unpExp;
  cvtMant_t unpMant;
  logic     unpIs32b;

  // FIFO head to converter
  logic     bufSign;
  cvtExp_t  bufExp;
  cvtMant_t bufMant;
  logic     bufIs32b;
  logic     bufNotEmpty;
  logic     bufPop;

  fpOperandUnpack unpack_i (
    .clk      (clk),
    .arstN    (arstN),
    .en       (en),
    .A        (A),
    .fmt      (fmt),
    .is32b    (is32b),
    .unpValid (unpValid),
    .unpSign  (unpSign),
    .unpExp   (unpExp),
    .unpMant  (unpMant),
    .unpIs32b (unpIs32b)
  );

  // a full FIFO is what the issuer sees as busy
  cvtOperandFifo #(
    .depth (`FPCVT_FIFO_DEPTH)
  ) fifo_i (
    .clk      (clk),
    .arstN    (arstN),
    .push     (unpValid),
    .inSign   (unpSign),
    .inExp    (unpExp),
    .inMant   (unpMant),
    .inIs32b  (unpIs32b),
    .pop      (bufPop),
    .outSign  (bufSign),
    .outExp   (bufExp),
    .outMant  (bufMant),
    .outIs32b (bufIs32b),
    .notEmpty (bufNotEmpty),
    .full     (busy)
  );

  fpToIntConvert convert_i (
    .clk      (clk),
    .arstN    (arstN),
    .clkEn    (clkEn),
    .notEmpty (bufNotEmpty),
    .sign     (bufSign),
    .exp      (bufExp),
    .mant     (bufMant),
    .is32b    (bufIs32b),
    .pop      (bufPop),
    .res      (res),
    .resValid (resValid)
  );

endmodule

// ==== fpCvtUnit_checker.sv ====
//**************************************************************************
// protocol checker bound to the conversion unit
//**************************************************************************

`timescale 1ns/1ps

module fpCvtUnit_checker (
  input logic              clk,
  input logic              arstN,
  input logic              en,
  input logic              busy,
  input logic              unpValid,
  input logic              bufPop,
  input logic              resValid,
  input fpCvtPkg::cvtInt_t res,
  input logic              s1Is32b
);

  // operands delivered by the unpacker and not yet taken by the converter
  int pending;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      pending <= 0;
    end else begin
      pending <= pending + (unpValid ? 1 : 0) - (bufPop ? 1 : 0);
    end
  end

  // issuer holds en back while the FIFO is full
  assert property (@(posedge clk) disable iff (!arstN) busy |-> !en)
    else $error("en raised while busy");

  assert property (@(posedge clk) disable iff (!arstN) bufPop |-> pending > 0)
    else $error("pop from an empty FIFO");

  assert property (@(posedge clk) !arstN |-> !resValid)
    else $error("resValid high during reset");

  // the stage 1 flag one edge back belongs to the result now announced
  assert property (@(posedge clk) disable iff (!arstN)
                   resValid && $past(s1Is32b) |-> res[63:32] == '0)
    else $error("32-bit result with a nonzero upper half");

endmodule

bind fpCvtUnit fpCvtUnit_checker checker_i (
  .clk      (clk),
  .arstN    (arstN),
  .en       (en),
  .busy     (busy),
  .unpValid (unpValid),
  .bufPop   (bufPop),
  .resValid (resValid),
  .res      (res),
  .s1Is32b  (convert_i.s1Is32b)
);

// ==== fpCvtTb.sv ====
//**************************************************************************
// testbench for the float-to-integer conversion unit
// replays the pattern file under random clkEn stalls, results in issue order
//**************************************************************************

`timescale 1ns/1ps

`include "fpCvt_settings.svh"

module fpCvtTb;
  import fpCvtPkg::*;

  localparam int numPat      = 24;
  localparam int numPass     = 2;
  localparam int numOps      = numPat * numPass;
  localparam int wordsPerPat = 4;
  localparam int limitCycles = 20 * numOps + 100;

  logic    clk;
  logic    arstN;
  logic    en;
  logic    clkEn;
  fpReg_t  A;
  fpFmt_e  fmt;
  logic    is32b;
  cvtInt_t res;
  logic    resValid;
  logic    busy;

  // four words per pattern: format, is32b, operand, expected result
  fpReg_t  patMem [numPat * wordsPerPat];
  cvtInt_t expQ [$];
  int      seed;
  int      issued;
  int      received;
  logic    lastEn;

  fpCvtUnit dut_i (
    .clk      (clk),
    .arstN    (arstN),
    .en       (en),
    .clkEn    (clkEn),
    .A        (A),
    .fmt      (fmt),
    .is32b    (is32b),
    .res      (res),
    .resValid (resValid),
    .busy     (busy)
  );

  always #4 clk = ~clk;

  task automatic abortRun();
    $display("test failed");
    $fatal(1, "simulation aborted");
  endtask

  task automatic checkInt(input string name, input cvtInt_t expected,
                          input cvtInt_t actual);
    if (actual !== expected) begin
      $display("FAIL %s: expected %h, actual %h", name, expected, actual);
      abortRun();
    end
  endtask

  // results come back in issue order, so the count names the pattern
  task automatic collectResult();
    string name;
    if (resValid) begin
      if (expQ.size() == 0) begin
        $display("a result arrived with no operation outstanding");
        abortRun();
      end else begin
        name = $sformatf("pattern %0d pass %0d", received % numPat, received / numPat);
        checkInt(name, expQ.pop_front(), res);
        received++;
      end
    end
  endtask

  task automatic issueOp(input int idx);
    int base;
    base  = (idx % numPat) * wordsPerPat;
    en    = 1'b1;
    fmt   = fpFmt_e'(patMem[base][3:0]);
    is32b = patMem[base + 1][0];
    A     = patMem[base + 2];
    expQ.push_back(patMem[base + 3][`FPCVT_INT_WIDTH-1:0]);
  endtask

  initial begin
    int r;
    logic gap;
    seed     = 44;
    clk      = 1'b0;
    arstN    = 1'b0;
    en       = 1'b0;
    clkEn    = 1'b0;
    A        = '0;
    fmt      = sng;
    is32b    = 1'b0;
    lastEn   = 1'b0;
    issued   = 0;
    received = 0;
    $readmemh("fpCvt_patterns.txt", patMem);
    if ($isunknown(patMem[numPat * wordsPerPat - 1])) begin
      $display("pattern file missing or shorter than %0d patterns", numPat);
      abortRun();
    end
    repeat (2) @(posedge clk);
    @(negedge clk);
    arstN = 1'b1;
    while (received < numOps) begin
      @(negedge clk);
      collectResult();
      r   = $random(seed);
      gap = (r[3:1] == 3'd0);
      if (busy || gap || issued == numOps) begin
        en = 1'b0;
        // an operand still heading into a full FIFO needs a pop at this edge
        clkEn  = (busy && lastEn) ? 1'b1 : r[0];
        lastEn = 1'b0;
      end else begin
        issueOp(issued);
        issued++;
        clkEn  = r[0];
        lastEn = 1'b1;
      end
    end
    @(negedge clk);
    if (resValid) begin
      $display("a result arrived after the last operation");
      abortRun();
    end else begin
      $display("test passed");
      $finish;
    end
  end

  // watchdog
  initial begin
    repeat (limitCycles) @(posedge clk);
    $display("watchdog expired after %0d cycles, results stopped arriving", limitCycles);
    abortRun();
  end

endmodule

// ==== fpCvt.f ====
+incdir+.
fpCvtPkg.sv
fpOperandUnpack.sv
cvtOperandFifo.sv
fpToIntConvert.sv
fpCvtUnit.sv
fpCvtUnit_checker.sv
fpCvtTb.sv

// ==== Bender.yml ====
package:
  name: fpCvt

export_include_dirs:
  - .

sources:
  - fpCvtPkg.sv
  - fpOperandUnpack.sv
  - cvtOperandFifo.sv
  - fpToIntConvert.sv
  - fpCvtUnit.sv
  - target: test
    files:
      - fpCvtUnit_checker.sv
      - fpCvtTb.sv

// ==== fpCvt_patterns.txt ====
// columns: format code, is32b, operand A, expected 64-bit result (all hex)
// format codes: 1 single, 2 double, 4 extended, 8 verbatim
1 0 40700000 0000000000000003 // 3.75
1 0 C0700000 FFFFFFFFFFFFFFFC // -3.75
1 0 3F800000 0000000000000001 // 1.0
1 0 BF000000 FFFFFFFFFFFFFFFF // -0.5
1 0 3F000000 0000000000000000 // 0.5
1 0 53800000 0000010000000000 // 2^40
1 0 5F000000 8000000000000000 // 2^63
1 0 DF000000 8000000000000000 // -2^63
1 1 C0700000 00000000FFFFFFFC // -3.75 as 32-bit
2 0 0000080B2200000000000 0000000000000064 // 100.25
2 0 0000180B2200000000000 FFFFFFFFFFFFFF9B // -100.25
2 1 0000180B2200000000000 00000000FFFFFF9B // -100.25 as 32-bit
2 0 000008660000000000001 0010000000000001 // 2^52+1, low bit below the gap
2 0 0000087E0000000000000 0000000000000000 // 2^64 above range
2 0 0000177E0000000000000 FFFFFFFFFFFFFFFF // -2^-64 below range
2 0 0000188A0000000000000 0000000000000000 // -2^70 above range
4 0 300138000000000000000 FFFFFFFFFFFFFA00 // -1536
4 0 2007DFDB9753076543210 FEDCBA9876543210 // exponent 63
4 1 2007DFDB9753076543210 0000000076543210 // exponent 63 as 32-bit
4 0 0FF7F0000000000000000 0000000000000000 // 2^-64 below range
4 1 1FF7F0000000000000000 00000000FFFFFFFF // -2^-64 as 32-bit
4 0 3007F0000000000000000 0000000000000000 // -2^64 above range
8 0 3AAAA2468ACF19ABCDEF0 123456789ABCDEF0 // junk in sign, exponent and bit 32
8 1 00001FFFFFFFE00000001 0000000000000001 // verbatim as 32-bit
